// ==== include/ie_cfg.svh ====
`ifndef IE_CFG_SVH
`define IE_CFG_SVH

// IDT vector per cause
`define IE_VEC_PROTECTION    32'd13
`define IE_VEC_PAGE_FAULT    32'd14
`define IE_VEC_INTERRUPT     32'd15

// Eight bytes per IDT entry
`define IE_ENTRY_SHIFT       32'd3

// Second word of the entry
`define IE_ENTRY_HIGH_OFFSET 32'd4

// Packets fed before the handler runs and after IRETD
`define IE_ENTRY_STEPS       9
`define IE_RETURN_STEPS      2

`endif

// ==== verilog/ie_pkg.sv ====
package ie_pkg;

    // Cause field from writeback, lowest set bit wins
    typedef struct packed {
        logic interrupt;
        logic page_fault;
        logic protection;
    } ie_cause_t;

    // State of the interrupted instruction
    typedef struct packed {
        logic [31:0] eip;
        logic [17:0] eflags;
        logic [15:0] cs;
    } wb_state_t;

    typedef struct packed {
        logic [31:0] entry_lo;
        logic [31:0] entry_hi;   // entry_lo + 4
    } entry_addr_t;

    // Opcode byte followed by a 32-bit immediate
    typedef struct packed {
        logic [7:0]  opcode;
        logic [31:0] immediate;   // Little-endian byte order
        logic [87:0] pad;
    } ie_imm_packet_t;

    // Same fetch word, two readings
    typedef union packed {
        ie_imm_packet_t   imm;
        logic [15:0][7:0] bytes;   // bytes[15] is the first byte fetched
    } ie_packet_u;

    typedef enum logic [3:0] {
        push_eflags,
        push_cs,
        push_eip,
        load_entry_lo,
        load_entry_hi,
        xchg_ax_bx,
        sar_eax,
        mov_cs,
        jmp_ebx,
        ret_far,
        pop_eflags
    } ie_step_t;

endpackage

// ==== verilog/ie_cause_decode.sv ====
`timescale 1ns/100ps
`include "ie_cfg.svh"

module ie_cause_decode import ie_pkg::*; (
    input  ie_cause_t   ie_type,
    input  logic [31:0] idtr_base,
    output entry_addr_t entry
);

    logic [31:0] vector;
    logic [31:0] vector_scaled;
    logic [31:0] entry_lo;

    // Priority pick, a zero cause falls through to interrupt
    always_comb begin
        if (ie_type.protection) begin
            vector = `IE_VEC_PROTECTION;
        end else if (ie_type.page_fault) begin
            vector = `IE_VEC_PAGE_FAULT;
        end else begin
            vector = `IE_VEC_INTERRUPT;
        end
    end

    assign vector_scaled = vector << `IE_ENTRY_SHIFT;   // Eight bytes per gate
    assign entry_lo      = idtr_base + vector_scaled;

    assign entry.entry_lo = entry_lo;
    assign entry.entry_hi = entry_lo + `IE_ENTRY_HIGH_OFFSET;

endmodule

// ==== verilog/ie_sequencer.sv ====
`timescale 1ns/100ps
`include "ie_cfg.svh"

module ie_sequencer import ie_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  logic     ie,
    input  logic     is_iretd,
    output ie_step_t step,
    output logic     step_valid,
    output logic     capture,
    output logic     packet_select,
    output logic     flush_pipe,
    output logic     ptc_clear,
    output logic     ld_eip,
    output logic     is_pop_eflags,
    output logic     servicing
);

    typedef enum logic [2:0] {
        st_idle,
        st_flush,
        st_packet,
        st_wait,
        st_ret_flush
    } seq_state_t;

    // Last packet of each run
    localparam ie_step_t last_entry_step  = ie_step_t'(`IE_ENTRY_STEPS - 1);
    localparam ie_step_t last_return_step =
        ie_step_t'(`IE_ENTRY_STEPS + `IE_RETURN_STEPS - 1);

    seq_state_t state_q;
    seq_state_t state_d;
    ie_step_t   step_q;
    ie_step_t   step_d;

    always_comb begin
        state_d = state_q;
        step_d  = step_q;
        case (state_q)
            st_idle: begin
                if (ie) begin
                    state_d = st_flush;
                end
            end
            st_flush: begin
                state_d = st_packet;
                step_d  = push_eflags;
            end
            st_packet: begin
                if (step_q == last_entry_step) begin
                    state_d = st_wait;   // Handler runs from here
                end else if (step_q == last_return_step) begin
                    state_d = st_ret_flush;
                end else begin
                    step_d = ie_step_t'(step_q + 4'd1);
                end
            end
            st_wait: begin
                if (is_iretd) begin
                    state_d = st_packet;
                    step_d  = ret_far;
                end
            end
            st_ret_flush: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // Enable low is the only stall
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
            step_q  <= push_eflags;
        end else if (enable) begin
            state_q <= state_d;
            step_q  <= step_d;
        end
    end

    assign step          = step_q;
    assign step_valid    = (state_q == st_packet);
    assign packet_select = (state_q == st_packet);   // Fetch takes packet over IBUFF
    assign capture       = (state_q == st_idle);
    assign flush_pipe    = (state_q == st_flush) || (state_q == st_ret_flush);
    assign ptc_clear     = flush_pipe;
    assign is_pop_eflags = (state_q == st_packet) && (step_q == pop_eflags);
    assign servicing     = (state_q != st_idle);

    // EIP reload in idle and on both control transfers
    assign ld_eip = (state_q == st_idle) ||
                    ((state_q == st_packet) && (step_q == jmp_ebx || step_q == ret_far));

    // Jump to the handler ends the entry run
    a_entry_end: assert property (
        @(posedge clk) disable iff (reset)
        (enable && step_valid && step_q == jmp_ebx) |=>
            (servicing && !step_valid && !flush_pipe)
    );

    a_return_end: assert property (
        @(posedge clk) disable iff (reset)
        (enable && is_pop_eflags) |=> (flush_pipe && servicing)   // Return flush follows
    );

endmodule

// ==== verilog/ie_packet_builder.sv ====
`timescale 1ns/100ps

module ie_packet_builder import ie_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        capture,
    input  ie_step_t    step,
    input  wb_state_t   wb,
    input  entry_addr_t entry,
    output ie_packet_u  packet
);

    wb_state_t   wb_q;
    entry_addr_t entry_q;

    function automatic logic [31:0] swap32(input logic [31:0] value);
        swap32 = {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

    // Snapshot of the interrupted instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_q    <= '0;
            entry_q <= '0;
        end else if (capture) begin
            wb_q    <= wb;
            entry_q <= entry;
        end
    end

    always_comb begin
        packet = '0;
        case (step)
            push_eflags: begin
                packet.imm.opcode    = 8'h68;
                packet.imm.immediate = swap32({14'b0, wb_q.eflags});
            end
            push_cs: begin
                packet.imm.opcode    = 8'h68;
                packet.imm.immediate = swap32({16'b0, wb_q.cs});
            end
            push_eip: begin
                packet.imm.opcode    = 8'h68;
                packet.imm.immediate = swap32(wb_q.eip);
            end
            load_entry_lo: begin
                packet.imm.opcode    = 8'ha1;   // MOV EAX, moffs32
                packet.imm.immediate = swap32(entry_q.entry_lo);
            end
            load_entry_hi: begin
                packet.imm.opcode    = 8'ha1;
                packet.imm.immediate = swap32(entry_q.entry_hi);
            end
            xchg_ax_bx: begin
                packet.bytes[15] = 8'h66;
                packet.bytes[14] = 8'h93;
            end
            sar_eax: begin
                packet.bytes[15] = 8'hc1;
                packet.bytes[14] = 8'hf8;
                packet.bytes[13] = 8'h04;
            end
            mov_cs: begin
                packet.bytes[15] = 8'h66;
                packet.bytes[14] = 8'h8e;
                packet.bytes[13] = 8'hc8;
            end
            jmp_ebx: begin
                packet.bytes[15] = 8'hff;
                packet.bytes[14] = 8'he3;
            end
            ret_far: begin
                packet.bytes[15] = 8'hcb;
            end
            pop_eflags: begin
                packet.bytes[15] = 8'h58;   // Popped word goes to EFLAGS
            end
            default: begin
                packet = '0;
            end
        endcase
    end

endmodule

// ==== verilog/ie_handler.sv ====
`timescale 1ns/100ps

module ie_handler import ie_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  logic        ie,
    input  ie_cause_t   ie_type,
    input  logic [31:0] idtr_base,
    input  wb_state_t   wb,
    input  logic        is_iretd,
    output ie_packet_u  packet,
    output logic        packet_select,
    output logic        flush_pipe,
    output logic        ptc_clear,
    output logic        ld_eip,
    output logic        is_pop_eflags,
    output logic        servicing
);

    entry_addr_t entry;
    ie_step_t    step;
    logic        capture;

    ie_cause_decode u_decode (
        .ie_type   (ie_type),
        .idtr_base (idtr_base),
        .entry     (entry)
    );

    ie_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .ie            (ie),
        .is_iretd      (is_iretd),
        .step          (step),
        .step_valid    (),
        .capture       (capture),
        .packet_select (packet_select),
        .flush_pipe    (flush_pipe),
        .ptc_clear     (ptc_clear),
        .ld_eip        (ld_eip),
        .is_pop_eflags (is_pop_eflags),
        .servicing     (servicing)
    );

    ie_packet_builder u_builder (
        .clk     (clk),
        .reset   (reset),
        .capture (capture),
        .step    (step),
        .wb      (wb),
        .entry   (entry),
        .packet  (packet)
    );

endmodule

// ==== testbench/tb_ie_handler.sv ====
`timescale 1ns/100ps
`include "ie_cfg.svh"

module tb_ie_handler import ie_pkg::*; ();

    localparam int model_idle      = 0;
    localparam int model_flush     = 1;
    localparam int model_packet    = 2;
    localparam int model_wait      = 3;
    localparam int model_ret_flush = 4;

    localparam int jmp_idx     = `IE_ENTRY_STEPS - 1;
    localparam int ret_far_idx = `IE_ENTRY_STEPS;
    localparam int pop_idx     = `IE_ENTRY_STEPS + `IE_RETURN_STEPS - 1;

    // Twenty times the summed sequence lengths, hold and wait cycles included
    localparam int run_count   = 20;
    localparam int seq_len     = `IE_ENTRY_STEPS + `IE_RETURN_STEPS + 10;
    localparam int cycle_limit = 20 * (run_count * seq_len + 16);

    logic        clk = 1'b0;
    logic        reset;
    logic        enable;
    logic        ie;
    ie_cause_t   ie_type;
    logic [31:0] idtr_base;
    wb_state_t   wb;
    logic        is_iretd;
    ie_packet_u  packet;
    logic        packet_select;
    logic        flush_pipe;
    logic        ptc_clear;
    logic        ld_eip;
    logic        is_pop_eflags;
    logic        servicing;

    int seed;
    int errors      = 0;
    int checks      = 0;
    int tests       = 0;
    int cycle_count = 0;

    int          m_state   = model_idle;
    int          m_step    = 0;
    logic        last_en   = 1'b0;
    wb_state_t   cap_wb    = '0;   // Snapshot taken on the ie edge
    logic [31:0] cap_base  = '0;
    logic [2:0]  cap_cause = '0;

    logic [5:0]   prev_ctrl;
    logic [127:0] prev_packet;
    bit           have_prev = 1'b0;

    int ie_age  = -1;
    int ret_age = -1;
    int sel_at  = -1;
    int jmp_at  = -1;
    int pop_at  = -1;
    int idle_at = -1;

    ie_handler u_dut (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .ie            (ie),
        .ie_type       (ie_type),
        .idtr_base     (idtr_base),
        .wb            (wb),
        .is_iretd      (is_iretd),
        .packet        (packet),
        .packet_select (packet_select),
        .flush_pipe    (flush_pipe),
        .ptc_clear     (ptc_clear),
        .ld_eip        (ld_eip),
        .is_pop_eflags (is_pop_eflags),
        .servicing     (servicing)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    function automatic logic pick_enable(input bit random_en);
        logic [31:0] word;
        word = random_word();
        return random_en ? (word[1:0] != 2'b00) : 1'b1;   // Three in four
    endfunction

    function automatic logic [31:0] byte_reverse(input logic [31:0] value);
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

    function automatic logic [31:0] vector_for(input logic [2:0] cause);
        if (cause[0]) begin
            return 32'd13;
        end else if (cause[1]) begin
            return 32'd14;
        end
        return 32'd15;   // Interrupt, also for a zero cause
    endfunction

    function automatic logic [127:0] expected_packet(input int step_idx);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = cap_base + (vector_for(cap_cause) << 3);
        hi = lo + 32'd4;
        case (step_idx)
            0:       return {8'h68, byte_reverse({14'b0, cap_wb.eflags}), 88'b0};
            1:       return {8'h68, byte_reverse({16'b0, cap_wb.cs}), 88'b0};
            2:       return {8'h68, byte_reverse(cap_wb.eip), 88'b0};
            3:       return {8'ha1, byte_reverse(lo), 88'b0};
            4:       return {8'ha1, byte_reverse(hi), 88'b0};
            5:       return {16'h6693, 112'b0};
            6:       return {24'hc1f804, 104'b0};
            7:       return {24'h668ec8, 104'b0};
            8:       return {16'hffe3, 112'b0};
            9:       return {8'hcb, 120'b0};
            10:      return {8'h58, 120'b0};
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s is %0h, expected %0h (cycle %0d)",
                     name, actual, expected, cycle_count);
        end
    endtask

    // Called on each rising edge with the inputs the DUT samples there
    task automatic advance_model();
        last_en = enable;
        if (enable) begin
            case (m_state)
                model_idle: begin
                    if (ie) begin
                        cap_wb    = wb;
                        cap_base  = idtr_base;
                        cap_cause = ie_type;
                        m_state   = model_flush;
                    end
                end
                model_flush: begin
                    m_state = model_packet;
                    m_step  = 0;
                end
                model_packet: begin
                    if (m_step == jmp_idx) begin
                        m_state = model_wait;
                    end else if (m_step == pop_idx) begin
                        m_state = model_ret_flush;
                    end else begin
                        m_step++;
                    end
                end
                model_wait: begin
                    if (is_iretd) begin
                        m_state = model_packet;
                        m_step  = ret_far_idx;
                    end
                end
                default: m_state = model_idle;
            endcase
        end
    endtask

    task automatic check_outputs();
        logic       in_packet;
        logic       flushing;
        logic       reload;
        logic [5:0] ctrl;
        in_packet = (m_state == model_packet);
        flushing  = (m_state == model_flush) || (m_state == model_ret_flush);
        reload    = (m_state == model_idle) ||
                    (in_packet && (m_step == jmp_idx || m_step == ret_far_idx));
        check_value("packet_select", 128'(packet_select), 128'(in_packet));
        check_value("flush_pipe", 128'(flush_pipe), 128'(flushing));
        check_value("ptc_clear", 128'(ptc_clear), 128'(flushing));
        check_value("ld_eip", 128'(ld_eip), 128'(reload));
        check_value("is_pop_eflags", 128'(is_pop_eflags), 128'(in_packet && m_step == pop_idx));
        check_value("servicing", 128'(servicing), 128'(m_state != model_idle));
        if (in_packet) begin
            check_value("packet", packet, expected_packet(m_step));
        end
        ctrl = {packet_select, flush_pipe, ptc_clear, ld_eip, is_pop_eflags, servicing};
        if (have_prev && !last_en) begin   // Stalled edge
            check_value("held controls", 128'(ctrl), 128'(prev_ctrl));
            if (packet_select) begin
                check_value("held packet", packet, prev_packet);
            end
        end
        prev_ctrl   = ctrl;
        prev_packet = packet;
        have_prev   = 1'b1;
    endtask

    task automatic drive_cycle(input logic en, input logic ie_v, input logic iretd_v,
                               input logic [2:0] cause);
        logic [31:0] word;
        @(posedge clk);
        advance_model();
        enable    <= en;
        ie        <= ie_v;
        is_iretd  <= iretd_v;
        ie_type   <= cause;
        idtr_base <= random_word();
        wb.eip    <= random_word();
        word = random_word();
        wb.eflags <= word[17:0];
        wb.cs     <= word[31:16];
        @(negedge clk);
        check_outputs();
        if (ie_age >= 0) begin
            ie_age++;
            if (packet_select && sel_at < 0) sel_at = ie_age;
            if (packet_select && ld_eip && jmp_at < 0) jmp_at = ie_age;
        end
        if (ret_age >= 0) begin
            ret_age++;
            if (is_pop_eflags && pop_at < 0) pop_at = ret_age;
            if (!servicing && idle_at < 0) idle_at = ret_age;
        end
    endtask

    task automatic run_interrupt(input logic [2:0] cause, input bit random_en);
        logic [31:0] word;
        ie_age  = -1;
        ret_age = -1;
        sel_at  = -1;
        jmp_at  = -1;
        pop_at  = -1;
        idle_at = -1;
        drive_cycle(pick_enable(random_en), 1'b1, 1'b0, cause);
        ie_age = 0;
        while (m_state == model_idle) begin
            drive_cycle(pick_enable(random_en), 1'b1, 1'b0, cause);
        end
        while (m_state != model_wait) begin   // Stray ie pulses are ignored here
            word = random_word();
            drive_cycle(pick_enable(random_en), word[1:0] == 2'b00, 1'b0, cause);
        end
        repeat (random_word() % 32'd4) begin
            drive_cycle(pick_enable(random_en), 1'b0, 1'b0, cause);
        end
        drive_cycle(pick_enable(random_en), 1'b0, 1'b1, cause);
        ret_age = 0;
        while (m_state == model_wait) begin
            drive_cycle(pick_enable(random_en), 1'b0, 1'b1, cause);
        end
        while (m_state != model_idle) begin
            drive_cycle(pick_enable(random_en), 1'b0, 1'b0, cause);
        end
        if (!random_en) begin
            check_value("first packet delay", 128'(sel_at), 128'(2));
            check_value("jmp_ebx delay", 128'(jmp_at), 128'(10));
            check_value("pop_eflags delay", 128'(pop_at), 128'(2));
            check_value("idle return delay", 128'(idle_at), 128'(4));
        end
        ie_age  = -1;
        ret_age = -1;
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        $display("test %-18s %s, %0d errors", name,
                 (errors == start) ? "passed" : "failed", errors - start);
    endtask

    initial begin
        int          start;
        logic [31:0] word;
        seed = 32'h5ee3a0d8;
        reset     <= 1'b1;
        enable    <= 1'b0;
        ie        <= 1'b0;
        ie_type   <= '0;
        idtr_base <= '0;
        wb        <= '0;
        is_iretd  <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        start = errors;
        @(negedge clk);
        check_outputs();
        report_test("reset_state", start);

        start = errors;
        for (int c = 0; c < 8; c++) begin
            run_interrupt(3'(c), 1'b0);
        end
        report_test("entry_enable_high", start);

        start = errors;
        repeat (12) begin
            word = random_word();
            run_interrupt(word[2:0], 1'b1);
        end
        report_test("random_enable", start);

        start = errors;
        repeat (6) drive_cycle(pick_enable(1'b1), 1'b0, 1'b1, 3'd4);
        repeat (2) drive_cycle(1'b1, 1'b0, 1'b0, 3'd4);
        check_value("servicing", 128'(servicing), 128'(0));
        report_test("iretd_in_idle", start);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
verilog/ie_pkg.sv
verilog/ie_cause_decode.sv
verilog/ie_sequencer.sv
verilog/ie_packet_builder.sv
verilog/ie_handler.sv
testbench/tb_ie_handler.sv

// ==== Makefile ====
sim := obj_dir/Vtb_ie_handler

.PHONY: all run clean

all: run

$(sim): tb.f $(wildcard verilog/*.sv testbench/*.sv include/*.svh)
	verilator --binary --timing --assert -f tb.f --top-module tb_ie_handler -Mdir obj_dir

run: $(sim)
	./$(sim) | tee /dev/stderr | grep -qx 'Finished with no errors'

clean:
	rm -rf obj_dir
